// File: logic/id_pkg.sv
`default_nettype none

package id_pkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;
	localparam logic [REG_ADDR_W-1:0] REG_LINK = 5'd31;

	// execute operations
	localparam int ALU_OP_W = 6;
	localparam logic [ALU_OP_W-1:0] ALU_OP_NOP = 6'd0;
	localparam logic [ALU_OP_W-1:0] ALU_OP_ADD = 6'd1;
	localparam logic [ALU_OP_W-1:0] ALU_OP_ADDU = 6'd2;
	localparam logic [ALU_OP_W-1:0] ALU_OP_SUB = 6'd3;
	localparam logic [ALU_OP_W-1:0] ALU_OP_SUBU = 6'd4;
	localparam logic [ALU_OP_W-1:0] ALU_OP_SLT = 6'd5;
	localparam logic [ALU_OP_W-1:0] ALU_OP_SLTU = 6'd6;
	localparam logic [ALU_OP_W-1:0] ALU_OP_AND = 6'd7;
	localparam logic [ALU_OP_W-1:0] ALU_OP_OR = 6'd8;
	localparam logic [ALU_OP_W-1:0] ALU_OP_XOR = 6'd9;
	localparam logic [ALU_OP_W-1:0] ALU_OP_NOR = 6'd10;
	localparam logic [ALU_OP_W-1:0] ALU_OP_SLL = 6'd11;
	localparam logic [ALU_OP_W-1:0] ALU_OP_SRL = 6'd12;
	localparam logic [ALU_OP_W-1:0] ALU_OP_SRA = 6'd13;
	localparam logic [ALU_OP_W-1:0] ALU_OP_LW = 6'd14;
	localparam logic [ALU_OP_W-1:0] ALU_OP_SW = 6'd15;
	localparam logic [ALU_OP_W-1:0] ALU_OP_BEQ = 6'd16;
	localparam logic [ALU_OP_W-1:0] ALU_OP_BNE = 6'd17;
	localparam logic [ALU_OP_W-1:0] ALU_OP_BGTZ = 6'd18;
	localparam logic [ALU_OP_W-1:0] ALU_OP_BLEZ = 6'd19;
	localparam logic [ALU_OP_W-1:0] ALU_OP_BGEZ = 6'd20;
	localparam logic [ALU_OP_W-1:0] ALU_OP_BLTZ = 6'd21;
	localparam logic [ALU_OP_W-1:0] ALU_OP_J = 6'd22;
	localparam logic [ALU_OP_W-1:0] ALU_OP_JAL = 6'd23;
	localparam logic [ALU_OP_W-1:0] ALU_OP_JR = 6'd24;
	localparam logic [ALU_OP_W-1:0] ALU_OP_JALR = 6'd25;

	// result groups
	localparam int ALU_SEL_W = 3;
	localparam logic [ALU_SEL_W-1:0] SEL_NOP = 3'd0;
	localparam logic [ALU_SEL_W-1:0] SEL_LOGIC = 3'd1;
	localparam logic [ALU_SEL_W-1:0] SEL_SHIFT = 3'd2;
	localparam logic [ALU_SEL_W-1:0] SEL_ARITH = 3'd3;
	localparam logic [ALU_SEL_W-1:0] SEL_LOAD_STORE = 3'd4;
	localparam logic [ALU_SEL_W-1:0] SEL_JUMP_BRANCH = 3'd5;

	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_REGIMM = 6'b000001;
	localparam logic [5:0] OP_J = 6'b000010;
	localparam logic [5:0] OP_JAL = 6'b000011;
	localparam logic [5:0] OP_BEQ = 6'b000100;
	localparam logic [5:0] OP_BNE = 6'b000101;
	localparam logic [5:0] OP_BLEZ = 6'b000110;
	localparam logic [5:0] OP_BGTZ = 6'b000111;
	localparam logic [5:0] OP_ADDI = 6'b001000;
	localparam logic [5:0] OP_ADDIU = 6'b001001;
	localparam logic [5:0] OP_SLTI = 6'b001010;
	localparam logic [5:0] OP_SLTIU = 6'b001011;
	localparam logic [5:0] OP_ANDI = 6'b001100;
	localparam logic [5:0] OP_ORI = 6'b001101;
	localparam logic [5:0] OP_XORI = 6'b001110;
	localparam logic [5:0] OP_LUI = 6'b001111;
	localparam logic [5:0] OP_LW = 6'b100011;
	localparam logic [5:0] OP_SW = 6'b101011;

	localparam logic [5:0] FUNCT_SLL = 6'b000000;
	localparam logic [5:0] FUNCT_SRL = 6'b000010;
	localparam logic [5:0] FUNCT_SRA = 6'b000011;
	localparam logic [5:0] FUNCT_SLLV = 6'b000100;
	localparam logic [5:0] FUNCT_SRLV = 6'b000110;
	localparam logic [5:0] FUNCT_SRAV = 6'b000111;
	localparam logic [5:0] FUNCT_JR = 6'b001000;
	localparam logic [5:0] FUNCT_JALR = 6'b001001;
	localparam logic [5:0] FUNCT_ADD = 6'b100000;
	localparam logic [5:0] FUNCT_ADDU = 6'b100001;
	localparam logic [5:0] FUNCT_SUB = 6'b100010;
	localparam logic [5:0] FUNCT_SUBU = 6'b100011;
	localparam logic [5:0] FUNCT_AND = 6'b100100;
	localparam logic [5:0] FUNCT_OR = 6'b100101;
	localparam logic [5:0] FUNCT_XOR = 6'b100110;
	localparam logic [5:0] FUNCT_NOR = 6'b100111;
	localparam logic [5:0] FUNCT_SLT = 6'b101010;
	localparam logic [5:0] FUNCT_SLTU = 6'b101011;

	// REGIMM selects on the rt field
	localparam logic [4:0] RT_BLTZ = 5'b00000;
	localparam logic [4:0] RT_BGEZ = 5'b00001;

	localparam logic [2:0] BR_NONE = 3'd0;
	localparam logic [2:0] BR_EQ = 3'd1;
	localparam logic [2:0] BR_NE = 3'd2;
	localparam logic [2:0] BR_GTZ = 3'd3;
	localparam logic [2:0] BR_LEZ = 3'd4;
	localparam logic [2:0] BR_GEZ = 3'd5;
	localparam logic [2:0] BR_LTZ = 3'd6;
	localparam logic [2:0] BR_JUMP = 3'd7;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm16;
	} i_fmt_t;

	typedef struct packed {
		logic [5:0] op;
		logic [25:0] target26;
	} j_fmt_t;

	// one fetched word, three ways of reading it
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		j_fmt_t j;
	} instr_u;

	typedef struct packed {
		logic [ALU_OP_W-1:0] alu_op;
		logic [ALU_SEL_W-1:0] alu_sel;
		logic rd1_en;
		logic rd2_en;
		logic [REG_ADDR_W-1:0] rs_addr;
		logic [REG_ADDR_W-1:0] rt_addr;
		logic [REG_ADDR_W-1:0] waddr;
		logic wreg;
		logic [XLEN-1:0] imm;
		logic [2:0] br_kind;
		logic link;
		logic invalid;
	} dec_ctrl_t;

	typedef struct packed {
		logic we;
		logic [REG_ADDR_W-1:0] waddr;
		logic [XLEN-1:0] wdata;
	} fwd_t;

	typedef struct packed {
		logic taken;
		logic [XLEN-1:0] target;
	} branch_t;

	typedef struct packed {
		logic valid;
		logic [ALU_OP_W-1:0] alu_op;
		logic [ALU_SEL_W-1:0] alu_sel;
		logic [XLEN-1:0] opnd1;
		logic [XLEN-1:0] opnd2;
		logic [XLEN-1:0] imm; // address offset for lw/sw
		logic [REG_ADDR_W-1:0] waddr;
		logic wreg;
		logic [XLEN-1:0] link_addr;
		logic in_delay_slot;
		logic invalid;
	} ex_ctrl_t;

endpackage

`default_nettype wire

// File: logic/fetch_latch.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_latch import id_pkg::*; (
	input wire logic clk_i,
	input wire logic rst_n_i,
	input wire logic fetch_valid_i,
	input wire logic [XLEN-1:0] pc_i,
	input wire logic [XLEN-1:0] inst_i,
	input wire logic stall_i,
	input wire logic branch_taken_i,
	output logic valid_o,
	output logic [XLEN-1:0] pc_o,
	output instr_u inst_o,
	output logic in_delay_slot_o
);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			valid_o <= 1'b0;
			pc_o <= '0;
			inst_o <= '0;
			in_delay_slot_o <= 1'b0;
		end else if (!stall_i) begin // hold everything on load-use
			valid_o <= fetch_valid_i;
			pc_o <= pc_i;
			inst_o <= inst_i;
			// word behind a taken branch is its delay slot
			in_delay_slot_o <= branch_taken_i;
		end
	end

endmodule

`default_nettype wire

// File: logic/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import id_pkg::*; (
	input wire logic valid_i,
	input wire instr_u inst_i,
	output dec_ctrl_t ctrl_o
);

	logic [XLEN-1:0] imm_sext;
	logic [XLEN-1:0] imm_zext;

	function automatic logic [ALU_SEL_W-1:0] sel_of(input logic [ALU_OP_W-1:0] op);
		case (op)
			ALU_OP_NOP: return SEL_NOP;
			ALU_OP_AND, ALU_OP_OR, ALU_OP_XOR, ALU_OP_NOR: return SEL_LOGIC;
			ALU_OP_SLL, ALU_OP_SRL, ALU_OP_SRA: return SEL_SHIFT;
			ALU_OP_ADD, ALU_OP_ADDU, ALU_OP_SUB, ALU_OP_SUBU,
			ALU_OP_SLT, ALU_OP_SLTU: return SEL_ARITH;
			ALU_OP_LW, ALU_OP_SW: return SEL_LOAD_STORE;
			default: return SEL_JUMP_BRANCH;
		endcase
	endfunction

	assign imm_sext = {{(XLEN-16){inst_i.i.imm16[15]}}, inst_i.i.imm16};
	assign imm_zext = {{(XLEN-16){1'b0}}, inst_i.i.imm16};

	always_comb begin
		ctrl_o = '0;
		ctrl_o.rs_addr = inst_i.r.rs;
		ctrl_o.rt_addr = inst_i.r.rt;
		ctrl_o.waddr = inst_i.i.rt; // i-type writes rt
		ctrl_o.imm = imm_sext;
		if (valid_i) begin
			case (inst_i.r.op)
				OP_SPECIAL: begin
					ctrl_o.rd1_en = 1'b1;
					ctrl_o.rd2_en = 1'b1;
					ctrl_o.waddr = inst_i.r.rd;
					ctrl_o.wreg = 1'b1;
					case (inst_i.r.funct)
						FUNCT_ADD: ctrl_o.alu_op = ALU_OP_ADD;
						FUNCT_ADDU: ctrl_o.alu_op = ALU_OP_ADDU;
						FUNCT_SUB: ctrl_o.alu_op = ALU_OP_SUB;
						FUNCT_SUBU: ctrl_o.alu_op = ALU_OP_SUBU;
						FUNCT_SLT: ctrl_o.alu_op = ALU_OP_SLT;
						FUNCT_SLTU: ctrl_o.alu_op = ALU_OP_SLTU;
						FUNCT_AND: ctrl_o.alu_op = ALU_OP_AND;
						FUNCT_OR: ctrl_o.alu_op = ALU_OP_OR;
						FUNCT_XOR: ctrl_o.alu_op = ALU_OP_XOR;
						FUNCT_NOR: ctrl_o.alu_op = ALU_OP_NOR;
						FUNCT_SLL, FUNCT_SLLV: ctrl_o.alu_op = ALU_OP_SLL;
						FUNCT_SRL, FUNCT_SRLV: ctrl_o.alu_op = ALU_OP_SRL;
						FUNCT_SRA, FUNCT_SRAV: ctrl_o.alu_op = ALU_OP_SRA;
						FUNCT_JR: begin
							ctrl_o.alu_op = ALU_OP_JR;
							ctrl_o.rd2_en = 1'b0;
							ctrl_o.wreg = 1'b0;
							ctrl_o.br_kind = BR_JUMP;
						end
						FUNCT_JALR: begin
							ctrl_o.alu_op = ALU_OP_JALR;
							ctrl_o.rd2_en = 1'b0;
							ctrl_o.br_kind = BR_JUMP;
							ctrl_o.link = 1'b1;
						end
						default: ctrl_o.invalid = 1'b1;
					endcase
					// sll/srl/sra take shamt in place of rs
					if (inst_i.r.funct[5:2] == 4'b0000) begin
						ctrl_o.rd1_en = 1'b0;
						ctrl_o.imm = {{(XLEN-5){1'b0}}, inst_i.r.shamt};
					end
				end
				OP_REGIMM: begin
					ctrl_o.rd1_en = 1'b1;
					case (inst_i.i.rt)
						RT_BLTZ: begin
							ctrl_o.alu_op = ALU_OP_BLTZ;
							ctrl_o.br_kind = BR_LTZ;
						end
						RT_BGEZ: begin
							ctrl_o.alu_op = ALU_OP_BGEZ;
							ctrl_o.br_kind = BR_GEZ;
						end
						default: ctrl_o.invalid = 1'b1;
					endcase
				end
				OP_J, OP_JAL: begin
					ctrl_o.alu_op = (inst_i.j.op == OP_JAL) ? ALU_OP_JAL : ALU_OP_J;
					ctrl_o.imm = {{(XLEN-28){1'b0}}, inst_i.j.target26, 2'b00};
					ctrl_o.br_kind = BR_JUMP;
					ctrl_o.waddr = REG_LINK;
					ctrl_o.wreg = (inst_i.j.op == OP_JAL);
					ctrl_o.link = (inst_i.j.op == OP_JAL);
				end
				OP_BEQ, OP_BNE: begin
					ctrl_o.alu_op = (inst_i.i.op == OP_BEQ) ? ALU_OP_BEQ : ALU_OP_BNE;
					ctrl_o.br_kind = (inst_i.i.op == OP_BEQ) ? BR_EQ : BR_NE;
					ctrl_o.rd1_en = 1'b1;
					ctrl_o.rd2_en = 1'b1;
				end
				OP_BLEZ, OP_BGTZ: begin
					ctrl_o.alu_op = (inst_i.i.op == OP_BLEZ) ? ALU_OP_BLEZ : ALU_OP_BGTZ;
					ctrl_o.br_kind = (inst_i.i.op == OP_BLEZ) ? BR_LEZ : BR_GTZ;
					ctrl_o.rd1_en = 1'b1;
				end
				OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
				OP_LW: begin
					ctrl_o.rd1_en = (inst_i.i.op != OP_LUI);
					ctrl_o.wreg = 1'b1;
					if (inst_i.i.op inside {OP_ANDI, OP_ORI, OP_XORI})
						ctrl_o.imm = imm_zext;
					case (inst_i.i.op)
						OP_ADDI: ctrl_o.alu_op = ALU_OP_ADD;
						OP_ADDIU: ctrl_o.alu_op = ALU_OP_ADDU;
						OP_SLTI: ctrl_o.alu_op = ALU_OP_SLT;
						OP_SLTIU: ctrl_o.alu_op = ALU_OP_SLTU;
						OP_ANDI: ctrl_o.alu_op = ALU_OP_AND;
						OP_ORI: ctrl_o.alu_op = ALU_OP_OR;
						OP_XORI: ctrl_o.alu_op = ALU_OP_XOR;
						OP_LUI: begin
							ctrl_o.alu_op = ALU_OP_OR; // imm | imm
							ctrl_o.imm = {inst_i.i.imm16, 16'h0};
						end
						default: ctrl_o.alu_op = ALU_OP_LW;
					endcase
				end
				OP_SW: begin
					ctrl_o.alu_op = ALU_OP_SW;
					ctrl_o.rd1_en = 1'b1;
					ctrl_o.rd2_en = 1'b1;
				end
				default: ctrl_o.invalid = 1'b1;
			endcase
			// unknown encoding, no reads, no write, no branch
			if (ctrl_o.invalid) begin
				ctrl_o.alu_op = ALU_OP_NOP;
				ctrl_o.rd1_en = 1'b0;
				ctrl_o.rd2_en = 1'b0;
				ctrl_o.wreg = 1'b0;
				ctrl_o.br_kind = BR_NONE;
				ctrl_o.link = 1'b0;
			end
		end
		ctrl_o.alu_sel = sel_of(ctrl_o.alu_op);
	end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import id_pkg::*; (
	input wire logic clk_i,
	input wire logic rst_n_i,
	input wire fwd_t wb_i,
	input wire logic [REG_ADDR_W-1:0] raddr1_i,
	input wire logic [REG_ADDR_W-1:0] raddr2_i,
	output logic [XLEN-1:0] rdata1_o,
	output logic [XLEN-1:0] rdata2_o
);

	logic [XLEN-1:0] regs [1:31]; // r0 not stored

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wb_i.we && wb_i.waddr != '0) begin
			regs[wb_i.waddr] <= wb_i.wdata;
		end
	end

	// no write-through, a write is seen after the edge
	assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

// File: logic/operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward import id_pkg::*; (
	input wire dec_ctrl_t ctrl_i,
	input wire logic [XLEN-1:0] rf_data1_i,
	input wire logic [XLEN-1:0] rf_data2_i,
	input wire fwd_t ex_fwd_i,
	input wire fwd_t mem_fwd_i,
	input wire logic ex_is_load_i,
	input wire logic [REG_ADDR_W-1:0] ex_waddr_i,
	output logic [XLEN-1:0] opnd1_o,
	output logic [XLEN-1:0] opnd2_o,
	output logic stall_o
);

	logic load_hit1;
	logic load_hit2;

	function automatic logic [XLEN-1:0] select_opnd(
		input logic en,
		input logic [REG_ADDR_W-1:0] addr,
		input logic [XLEN-1:0] rf_data,
		input logic [XLEN-1:0] imm,
		input fwd_t ex_fwd,
		input fwd_t mem_fwd
	);
		if (!en)
			return imm;
		if (addr == '0)
			return '0;
		// youngest result first
		if (ex_fwd.we && ex_fwd.waddr == addr)
			return ex_fwd.wdata;
		if (mem_fwd.we && mem_fwd.waddr == addr)
			return mem_fwd.wdata;
		return rf_data;
	endfunction

	assign opnd1_o = select_opnd(ctrl_i.rd1_en, ctrl_i.rs_addr, rf_data1_i, ctrl_i.imm,
		ex_fwd_i, mem_fwd_i);
	assign opnd2_o = select_opnd(ctrl_i.rd2_en, ctrl_i.rt_addr, rf_data2_i, ctrl_i.imm,
		ex_fwd_i, mem_fwd_i);

	// lw data not ready until mem, wait one cycle
	assign load_hit1 = ctrl_i.rd1_en && ctrl_i.rs_addr != '0 && ctrl_i.rs_addr == ex_waddr_i;
	assign load_hit2 = ctrl_i.rd2_en && ctrl_i.rt_addr != '0 && ctrl_i.rt_addr == ex_waddr_i;
	assign stall_o = ex_is_load_i && (load_hit1 || load_hit2);

endmodule

`default_nettype wire

// File: logic/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit import id_pkg::*; (
	input wire dec_ctrl_t ctrl_i,
	input wire logic [XLEN-1:0] pc_i,
	input wire logic [XLEN-1:0] opnd1_i,
	input wire logic [XLEN-1:0] opnd2_i,
	input wire logic stall_i,
	output branch_t branch_o,
	output logic [XLEN-1:0] link_addr_o
);

	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] pc_plus8;
	logic [XLEN-1:0] rel_target;
	logic cond;

	assign pc_plus4 = pc_i + 32'd4;
	assign pc_plus8 = pc_i + 32'd8; // skip the delay slot
	assign rel_target = pc_plus4 + {ctrl_i.imm[XLEN-3:0], 2'b00};

	always_comb begin
		case (ctrl_i.br_kind)
			BR_EQ: cond = (opnd1_i == opnd2_i);
			BR_NE: cond = (opnd1_i != opnd2_i);
			BR_GTZ: cond = !opnd1_i[XLEN-1] && opnd1_i != '0;
			BR_LEZ: cond = opnd1_i[XLEN-1] || opnd1_i == '0;
			BR_GEZ: cond = !opnd1_i[XLEN-1];
			BR_LTZ: cond = opnd1_i[XLEN-1];
			BR_JUMP: cond = 1'b1;
			default: cond = 1'b0;
		endcase
	end

	always_comb begin
		if (ctrl_i.br_kind != BR_JUMP)
			branch_o.target = rel_target;
		else if (ctrl_i.rd1_en)
			branch_o.target = opnd1_i; // jr, jalr
		else
			branch_o.target = {pc_plus4[XLEN-1:28], ctrl_i.imm[27:0]};
	end

	// operands are stale while stalled
	assign branch_o.taken = cond && !stall_i;
	assign link_addr_o = ctrl_i.link ? pc_plus8 : '0;

endmodule

`default_nettype wire

// File: logic/id_ex_register.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_register import id_pkg::*; (
	input wire logic clk_i,
	input wire logic rst_n_i,
	input wire logic valid_i,
	input wire logic stall_i,
	input wire dec_ctrl_t ctrl_i,
	input wire logic [XLEN-1:0] opnd1_i,
	input wire logic [XLEN-1:0] opnd2_i,
	input wire logic [XLEN-1:0] link_addr_i,
	input wire logic in_delay_slot_i,
	output ex_ctrl_t ex_o
);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i || stall_i || !valid_i) begin
			ex_o <= '0; // bubble
		end else begin
			ex_o.valid <= 1'b1;
			ex_o.alu_op <= ctrl_i.alu_op;
			ex_o.alu_sel <= ctrl_i.alu_sel;
			ex_o.opnd1 <= opnd1_i;
			ex_o.opnd2 <= opnd2_i;
			ex_o.imm <= ctrl_i.imm;
			ex_o.waddr <= ctrl_i.waddr;
			ex_o.wreg <= ctrl_i.wreg;
			ex_o.link_addr <= link_addr_i;
			ex_o.in_delay_slot <= in_delay_slot_i;
			ex_o.invalid <= ctrl_i.invalid;
		end
	end

endmodule

`default_nettype wire

// File: logic/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage import id_pkg::*; (
	input wire logic clk_i,
	input wire logic rst_n_i,
	input wire logic fetch_valid_i,
	input wire logic [XLEN-1:0] pc_i,
	input wire logic [XLEN-1:0] inst_i,
	input wire fwd_t ex_fwd_i,
	input wire fwd_t mem_fwd_i,
	input wire fwd_t wb_i,
	output logic stall_o,
	output branch_t branch_o,
	output ex_ctrl_t ex_o
);

	logic dec_valid;
	logic [XLEN-1:0] dec_pc;
	instr_u dec_inst;
	logic dec_delay_slot;
	dec_ctrl_t dec_ctrl;
	logic [XLEN-1:0] rf_data1;
	logic [XLEN-1:0] rf_data2;
	logic [XLEN-1:0] opnd1;
	logic [XLEN-1:0] opnd2;
	logic [XLEN-1:0] link_addr;

	fetch_latch u_fetch_latch (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.fetch_valid_i(fetch_valid_i),
		.pc_i(pc_i),
		.inst_i(inst_i),
		.stall_i(stall_o),
		.branch_taken_i(branch_o.taken),
		.valid_o(dec_valid),
		.pc_o(dec_pc),
		.inst_o(dec_inst),
		.in_delay_slot_o(dec_delay_slot)
	);

	inst_decoder u_inst_decoder (
		.valid_i(dec_valid),
		.inst_i(dec_inst),
		.ctrl_o(dec_ctrl)
	);

	reg_file u_reg_file (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.wb_i(wb_i),
		.raddr1_i(dec_ctrl.rs_addr),
		.raddr2_i(dec_ctrl.rt_addr),
		.rdata1_o(rf_data1),
		.rdata2_o(rf_data2)
	);

	// load in id/ex is what execute holds next cycle
	operand_forward u_operand_forward (
		.ctrl_i(dec_ctrl),
		.rf_data1_i(rf_data1),
		.rf_data2_i(rf_data2),
		.ex_fwd_i(ex_fwd_i),
		.mem_fwd_i(mem_fwd_i),
		.ex_is_load_i(ex_o.valid && ex_o.alu_op == ALU_OP_LW),
		.ex_waddr_i(ex_o.waddr),
		.opnd1_o(opnd1),
		.opnd2_o(opnd2),
		.stall_o(stall_o)
	);

	branch_unit u_branch_unit (
		.ctrl_i(dec_ctrl),
		.pc_i(dec_pc),
		.opnd1_i(opnd1),
		.opnd2_i(opnd2),
		.stall_i(stall_o),
		.branch_o(branch_o),
		.link_addr_o(link_addr)
	);

	id_ex_register u_id_ex_register (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.valid_i(dec_valid),
		.stall_i(stall_o),
		.ctrl_i(dec_ctrl),
		.opnd1_i(opnd1),
		.opnd2_i(opnd2),
		.link_addr_i(link_addr),
		.in_delay_slot_i(dec_delay_slot),
		.ex_o(ex_o)
	);

endmodule

`default_nettype wire

// File: testbench/id_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_tb import id_pkg::*; ();

	localparam int NUM_INSTR = 2000;
	localparam int RESET_CYCLES = 10;
	localparam longint LIMIT_NS = (longint'(NUM_INSTR) * 4 + RESET_CYCLES) * 100;

	logic clk_i = 1'b0;
	logic rst_n_i;
	logic fetch_valid_i;
	logic [XLEN-1:0] pc_i;
	logic [XLEN-1:0] inst_i;
	fwd_t ex_fwd_i;
	fwd_t mem_fwd_i;
	fwd_t wb_i;
	logic stall_o;
	branch_t branch_o;
	ex_ctrl_t ex_o;

	logic [31:0] lfsr = 32'h1a85;
	int errors = 0;
	int checks = 0;
	int stalls = 0;

	// model of latch, id/ex and register file
	logic m_valid, m_ds;
	logic [31:0] m_pc, m_inst;
	logic [31:0] rf [32];
	logic e_valid, e_wreg, e_ds, e_inv;
	logic [5:0] e_op;
	logic [2:0] e_sel;
	logic [4:0] e_waddr;
	logic [31:0] e_o1, e_o2, e_link, e_imm;
	ex_ctrl_t p_ex; // next id/ex content
	// decoded fields of the word in decode
	logic d_rd1, d_rd2, d_wreg, d_link, d_inv;
	logic [5:0] d_op;
	logic [2:0] d_sel, d_kind;
	logic [4:0] d_wa;
	logic [31:0] d_imm;
	logic x_stall, x_taken;

	always #50 clk_i = ~clk_i;

	id_stage id_stage_inst (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.fetch_valid_i(fetch_valid_i),
		.pc_i(pc_i),
		.inst_i(inst_i),
		.ex_fwd_i(ex_fwd_i),
		.mem_fwd_i(mem_fwd_i),
		.wb_i(wb_i),
		.stall_o(stall_o),
		.branch_o(branch_o),
		.ex_o(ex_o)
	);

	function automatic logic [31:0] take(input int n);
		logic [31:0] v;
		logic b;
		v = '0;
		for (int k = 0; k < n; k++) begin
			b = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // taps 32,22,2,1
			lfsr = {lfsr[30:0], b};
			v = {v[30:0], b};
		end
		return v;
	endfunction

	function automatic logic [4:0] pick_reg();
		logic [4:0] few [4];
		few = '{5'd1, 5'd2, 5'd3, 5'd31};
		if (take(2) == 0)
			return take(5);
		return few[take(2)];
	endfunction

	function automatic fwd_t random_bus();
		fwd_t f;
		f.we = take(1);
		f.waddr = pick_reg();
		f.wdata = take(32);
		return f;
	endfunction

	function automatic logic [31:0] random_instr();
		logic [5:0] rfun [16];
		logic [5:0] iops [8];
		logic [4:0] rs, rt, rd, sh;
		logic [15:0] imm;
		logic [25:0] tgt;
		rfun = '{FUNCT_ADD, FUNCT_ADDU, FUNCT_SUB, FUNCT_SUBU, FUNCT_SLT, FUNCT_SLTU,
			FUNCT_AND, FUNCT_OR, FUNCT_XOR, FUNCT_NOR, FUNCT_SLLV, FUNCT_SRLV,
			FUNCT_SRAV, FUNCT_SLL, FUNCT_SRL, FUNCT_SRA};
		iops = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
		rs = pick_reg();
		rt = pick_reg();
		rd = pick_reg();
		imm = take(16);
		sh = take(5);
		tgt = take(26);
		case (take(5))
			3: return {OP_SPECIAL, rs, 15'd0, FUNCT_JR};
			4: return {OP_SPECIAL, rs, 5'd0, rd, 5'd0, FUNCT_JALR};
			5, 6, 7: return {iops[take(3)], rs, rt, imm};
			8, 9: return {OP_LW, rs, rt, imm};
			10: return {OP_SW, rs, rt, imm};
			11: return {OP_BEQ, rs, rt, imm};
			12: return {OP_BNE, rs, rt, imm};
			13: return {OP_BGTZ, rs, 5'd0, imm};
			14: return {OP_BLEZ, rs, 5'd0, imm};
			15: return {OP_REGIMM, rs, RT_BGEZ, imm};
			16: return {OP_REGIMM, rs, RT_BLTZ, imm};
			17: return {OP_J, tgt};
			18: return {OP_JAL, tgt};
			19, 20: return take(32); // mostly unknown encodings
			default: return {OP_SPECIAL, rs, rt, rd, sh, rfun[take(4)]};
		endcase
	endfunction

	function automatic logic [2:0] group_of(input logic [5:0] op);
		if (op == ALU_OP_NOP)
			return SEL_NOP;
		if (op inside {ALU_OP_AND, ALU_OP_OR, ALU_OP_XOR, ALU_OP_NOR})
			return SEL_LOGIC;
		if (op inside {ALU_OP_SLL, ALU_OP_SRL, ALU_OP_SRA})
			return SEL_SHIFT;
		if (op inside {[ALU_OP_ADD:ALU_OP_SLTU]})
			return SEL_ARITH;
		if (op inside {ALU_OP_LW, ALU_OP_SW})
			return SEL_LOAD_STORE;
		return SEL_JUMP_BRANCH;
	endfunction

	task automatic decode(input logic v, input logic [31:0] w);
		logic [5:0] op, funct;
		op = w[31:26];
		funct = w[5:0];
		{d_op, d_rd1, d_rd2, d_wreg, d_kind, d_link, d_inv} = '0;
		d_wa = w[20:16];
		d_imm = {{16{w[15]}}, w[15:0]};
		if (v) begin
			case (op)
				OP_SPECIAL: begin
					{d_rd1, d_rd2, d_wreg} = 3'b111;
					d_wa = w[15:11];
					case (funct)
						FUNCT_ADD: d_op = ALU_OP_ADD;
						FUNCT_ADDU: d_op = ALU_OP_ADDU;
						FUNCT_SUB: d_op = ALU_OP_SUB;
						FUNCT_SUBU: d_op = ALU_OP_SUBU;
						FUNCT_SLT: d_op = ALU_OP_SLT;
						FUNCT_SLTU: d_op = ALU_OP_SLTU;
						FUNCT_AND: d_op = ALU_OP_AND;
						FUNCT_OR: d_op = ALU_OP_OR;
						FUNCT_XOR: d_op = ALU_OP_XOR;
						FUNCT_NOR: d_op = ALU_OP_NOR;
						FUNCT_SLL, FUNCT_SLLV: d_op = ALU_OP_SLL;
						FUNCT_SRL, FUNCT_SRLV: d_op = ALU_OP_SRL;
						FUNCT_SRA, FUNCT_SRAV: d_op = ALU_OP_SRA;
						FUNCT_JR: {d_op, d_rd2, d_wreg, d_kind} = {ALU_OP_JR, 2'b00, BR_JUMP};
						FUNCT_JALR: {d_op, d_rd2, d_kind, d_link} = {ALU_OP_JALR, 1'b0, BR_JUMP, 1'b1};
						default: d_inv = 1'b1;
					endcase
					if (funct inside {FUNCT_SLL, FUNCT_SRL, FUNCT_SRA}) begin
						d_rd1 = 1'b0;
						d_imm = {27'd0, w[10:6]};
					end
				end
				OP_REGIMM: begin
					d_rd1 = 1'b1;
					if (w[20:16] == RT_BLTZ) {d_op, d_kind} = {ALU_OP_BLTZ, BR_LTZ};
					else if (w[20:16] == RT_BGEZ) {d_op, d_kind} = {ALU_OP_BGEZ, BR_GEZ};
					else d_inv = 1'b1;
				end
				OP_J, OP_JAL: begin
					d_op = (op == OP_JAL) ? ALU_OP_JAL : ALU_OP_J;
					d_imm = {4'd0, w[25:0], 2'b00};
					d_kind = BR_JUMP;
					d_wa = REG_LINK;
					d_wreg = (op == OP_JAL);
					d_link = (op == OP_JAL);
				end
				OP_BEQ: {d_op, d_kind, d_rd1, d_rd2} = {ALU_OP_BEQ, BR_EQ, 2'b11};
				OP_BNE: {d_op, d_kind, d_rd1, d_rd2} = {ALU_OP_BNE, BR_NE, 2'b11};
				OP_BLEZ: {d_op, d_kind, d_rd1} = {ALU_OP_BLEZ, BR_LEZ, 1'b1};
				OP_BGTZ: {d_op, d_kind, d_rd1} = {ALU_OP_BGTZ, BR_GTZ, 1'b1};
				OP_ADDI: {d_op, d_rd1, d_wreg} = {ALU_OP_ADD, 2'b11};
				OP_ADDIU: {d_op, d_rd1, d_wreg} = {ALU_OP_ADDU, 2'b11};
				OP_SLTI: {d_op, d_rd1, d_wreg} = {ALU_OP_SLT, 2'b11};
				OP_SLTIU: {d_op, d_rd1, d_wreg} = {ALU_OP_SLTU, 2'b11};
				OP_ANDI: {d_op, d_rd1, d_wreg, d_imm} = {ALU_OP_AND, 2'b11, 16'd0, w[15:0]};
				OP_ORI: {d_op, d_rd1, d_wreg, d_imm} = {ALU_OP_OR, 2'b11, 16'd0, w[15:0]};
				OP_XORI: {d_op, d_rd1, d_wreg, d_imm} = {ALU_OP_XOR, 2'b11, 16'd0, w[15:0]};
				OP_LUI: {d_op, d_wreg, d_imm} = {ALU_OP_OR, 1'b1, w[15:0], 16'd0};
				OP_LW: {d_op, d_rd1, d_wreg} = {ALU_OP_LW, 2'b11};
				OP_SW: {d_op, d_rd1, d_rd2} = {ALU_OP_SW, 2'b11};
				default: d_inv = 1'b1;
			endcase
			if (d_inv)
				{d_op, d_rd1, d_rd2, d_wreg, d_kind, d_link} = '0;
		end
		d_sel = group_of(d_op);
	endtask

	function automatic logic [31:0] operand(input logic en, input logic [4:0] a);
		if (!en)
			return d_imm;
		if (a == 0)
			return '0;
		if (ex_fwd_i.we && ex_fwd_i.waddr == a)
			return ex_fwd_i.wdata;
		if (mem_fwd_i.we && mem_fwd_i.waddr == a)
			return mem_fwd_i.wdata;
		return rf[a];
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("error %s: expected %h actual %h at %0t", name, exp, act, $time);
		end
	endtask

	// expected outputs for the current cycle
	task automatic evaluate();
		logic [31:0] o1, o2, pc4, target;
		logic [4:0] rs, rt;
		logic cond;
		rs = m_inst[25:21];
		rt = m_inst[20:16];
		decode(m_valid, m_inst);
		o1 = operand(d_rd1, rs);
		o2 = operand(d_rd2, rt);
		x_stall = e_valid && e_op == ALU_OP_LW &&
			((d_rd1 && rs != 0 && rs == e_waddr) || (d_rd2 && rt != 0 && rt == e_waddr));
		case (d_kind)
			BR_EQ: cond = (o1 == o2);
			BR_NE: cond = (o1 != o2);
			BR_GTZ: cond = $signed(o1) > 0;
			BR_LEZ: cond = $signed(o1) <= 0;
			BR_GEZ: cond = $signed(o1) >= 0;
			BR_LTZ: cond = $signed(o1) < 0;
			BR_JUMP: cond = 1'b1;
			default: cond = 1'b0;
		endcase
		x_taken = cond && !x_stall;
		pc4 = m_pc + 4;
		if (d_kind != BR_JUMP) target = pc4 + {d_imm[29:0], 2'b00};
		else if (d_rd1) target = o1;
		else target = {pc4[31:28], m_inst[25:0], 2'b00};
		check_val("stall", x_stall, stall_o);
		check_val("branch taken", x_taken, branch_o.taken);
		if (x_taken)
			check_val("branch target", target, branch_o.target);
		check_val("ex valid", e_valid, ex_o.valid);
		check_val("ex wreg", e_wreg, ex_o.wreg);
		if (e_valid) begin
			check_val("ex alu_op", e_op, ex_o.alu_op);
			check_val("ex alu_sel", e_sel, ex_o.alu_sel);
			check_val("ex invalid", e_inv, ex_o.invalid);
			check_val("ex delay slot", e_ds, ex_o.in_delay_slot);
			check_val("ex link addr", e_link, ex_o.link_addr);
			if (e_wreg)
				check_val("ex waddr", e_waddr, ex_o.waddr);
			if (!e_inv) begin
				check_val("ex opnd1", e_o1, ex_o.opnd1);
				check_val("ex opnd2", e_o2, ex_o.opnd2);
				check_val("ex imm", e_imm, ex_o.imm);
			end
		end
		p_ex = '0;
		if (m_valid && !x_stall) begin
			p_ex.valid = 1'b1;
			{p_ex.alu_op, p_ex.alu_sel, p_ex.waddr, p_ex.wreg} = {d_op, d_sel, d_wa, d_wreg};
			{p_ex.opnd1, p_ex.opnd2, p_ex.invalid} = {o1, o2, d_inv};
			p_ex.imm = d_imm;
			p_ex.link_addr = d_link ? m_pc + 8 : '0;
			p_ex.in_delay_slot = m_ds;
		end
	endtask

	initial begin
		#(LIMIT_NS);
		$display("timeout: the stage stopped accepting instructions after %0d ns", LIMIT_NS);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		int accepted;
		int cyc;
		logic [31:0] pc;
		rst_n_i = 1'b0;
		fetch_valid_i = 1'b0;
		pc_i = '0;
		inst_i = '0;
		ex_fwd_i = '0;
		mem_fwd_i = '0;
		wb_i = '0;
		accepted = 0;
		cyc = 0;
		pc = 32'h0040_0000;
		{m_valid, m_ds, m_pc, m_inst} = '0;
		{e_valid, e_wreg, e_ds, e_inv, e_op, e_sel, e_waddr, e_o1, e_o2, e_link} = '0;
		e_imm = '0;
		while (accepted < NUM_INSTR) begin
			@(negedge clk_i);
			evaluate();
			@(posedge clk_i);
			if (!rst_n_i) begin
				{m_valid, m_ds} = '0;
				{e_valid, e_wreg, e_op, e_sel} = '0;
				for (int r = 0; r < 32; r++)
					rf[r] = '0;
			end else begin
				{e_valid, e_op, e_sel, e_waddr, e_wreg} = {p_ex.valid, p_ex.alu_op,
					p_ex.alu_sel, p_ex.waddr, p_ex.wreg};
				{e_o1, e_o2, e_link, e_ds, e_inv} = {p_ex.opnd1, p_ex.opnd2,
					p_ex.link_addr, p_ex.in_delay_slot, p_ex.invalid};
				e_imm = p_ex.imm;
				if (wb_i.we && wb_i.waddr != 0)
					rf[wb_i.waddr] = wb_i.wdata;
				if (x_stall) begin
					stalls++;
				end else begin
					{m_valid, m_pc, m_inst, m_ds} = {fetch_valid_i, pc_i, inst_i, x_taken};
					accepted++;
				end
			end
			cyc++;
			if (cyc == RESET_CYCLES)
				rst_n_i <= 1'b1;
			if (!x_stall || !rst_n_i) begin // fetch holds while stalled
				pc = pc + 4;
				fetch_valid_i <= (take(3) != 0);
				pc_i <= pc;
				inst_i <= random_instr();
			end
			ex_fwd_i <= random_bus();
			mem_fwd_i <= random_bus();
			wb_i <= random_bus();
		end
		$display("checks %0d, stalls %0d, errors %0d", checks, stalls, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: id_stage.f
logic/id_pkg.sv
logic/fetch_latch.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/operand_forward.sv
logic/branch_unit.sv
logic/id_ex_register.sv
logic/id_stage.sv
testbench/id_stage_tb.sv

// File: Bender.yml
package:
  name: id_stage

sources:
  - logic/id_pkg.sv
  - logic/fetch_latch.sv
  - logic/inst_decoder.sv
  - logic/reg_file.sv
  - logic/operand_forward.sv
  - logic/branch_unit.sv
  - logic/id_ex_register.sv
  - logic/id_stage.sv
  - target: simulation
    files:
      - testbench/id_stage_tb.sv
